/* verif/dot_cases.txt */
// Per case, three lines: A[0..15], then B[0..15], then the expected 24-bit sum.
// All hex; elements are signed 8-bit, the sum is two's complement.
01 01 01 01 01 01 01 01 01 01 01 01 01 01 01 01
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
000088
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
040000
7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f 7f
80 80 80 80 80 80 80 80 80 80 80 80 80 80 80 80
fc0800
01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f 10
01 ff 01 ff 01 ff 01 ff 01 ff 01 ff 01 ff 01 ff
fffff8
ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
00 01 02 03 04 05 06 07 08 09 0a 0b 0c 0d 0e 0f
ffff88
02 fe 03 fd 10 f0 7f 81 00 01 40 c0 05 fb 0a f6
03 03 fe fe 04 04 02 02 7f 80 02 02 10 10 ff ff
ffff80

/* flist.f */
rtl/dp_cfg_pkg.sv
rtl/dp_regs_pkg.sv
rtl/operand_bram.sv
rtl/vector_loader.sv
rtl/wb_decode.sv
rtl/dot_execute.sv
rtl/result_status.sv
rtl/dot_top.sv
verif/dot_tb.sv

/* verif/dot_tb.sv */
`timescale 1ns/100ps

module dot_tb;

  localparam int max_cases       = 16;
  localparam int ack_wait_max    = 8;
  localparam int poll_max        = 40;
  localparam int writes_per_case = 2 * dp_cfg_pkg::vec_len;

  logic                 clk;
  logic                 rst_n;
  logic                 wb_cyc;
  logic                 wb_stb;
  logic                 wb_we;
  dp_regs_pkg::wb_adr_t wb_adr;
  dp_regs_pkg::wb_dat_t wb_dat_w;
  dp_regs_pkg::wb_dat_t wb_dat_r;
  logic                 wb_ack;

  dp_cfg_pkg::elem_t  case_a [0:max_cases-1][0:dp_cfg_pkg::vec_len-1];
  dp_cfg_pkg::elem_t  case_b [0:max_cases-1][0:dp_cfg_pkg::vec_len-1];
  dp_cfg_pkg::acc_t   case_sum [0:max_cases-1];
  int                 num_cases;
  int                 fd;
  logic [31:0]        lfsr;
  int                 cycles;
  int                 cycle_limit;
  dp_regs_pkg::runs_t runs_exp;

  dot_top UUT (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack)
  );

  always #4 clk = ~clk;   // 8 ns period.

  //////////////////////////////
  // Failure and compares
  //////////////////////////////

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic check_result(input string name, input dp_cfg_pkg::acc_t exp,
                              input dp_cfg_pkg::acc_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("** Error %s: result expected %0d (0x%h), actual %0d (0x%h)",
                              name, exp, exp, act, act));
    end
  endtask

  task automatic check_runs(input string name, input dp_regs_pkg::runs_t exp,
                            input dp_regs_pkg::runs_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("** Error %s: runs expected %0d, actual %0d", name, exp, act));
    end
  endtask

  task automatic check_status(input string name, input logic exp_busy, input logic exp_done,
                              input dp_regs_pkg::wb_dat_t word);
    logic act_busy;
    logic act_done;
    act_busy = word[dp_regs_pkg::status_busy_bit];
    act_done = word[dp_regs_pkg::status_done_bit];
    if (act_busy !== exp_busy || act_done !== exp_done) begin
      stop_on_error($sformatf("** Error %s: busy/done expected %b/%b, actual %b/%b",
                              name, exp_busy, exp_done, act_busy, act_done));
    end
  endtask

  task automatic check_word(input string name, input dp_regs_pkg::wb_dat_t exp,
                            input dp_regs_pkg::wb_dat_t act);
    if (act !== exp) begin
      stop_on_error($sformatf("** Error %s: word expected 0x%h, actual 0x%h", name, exp, act));
    end
  endtask

  // Timeout sized from the number of cases.
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      stop_on_error($sformatf("Timeout: %0d cycles used before all cases completed.", cycles));
    end
  end

  //////////////////////////////
  // Random gaps and bus driver
  //////////////////////////////

  // Taps 32, 22, 2, 1.
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic idle_gap();
    int gap;
    gap = 0;
    repeat (2) begin
      lfsr = lfsr_next(lfsr);
      gap  = (gap << 1) | lfsr[0];   // One step per bit.
    end
    repeat (gap) @(negedge clk);
  endtask

  // Starts and ends on a falling edge.
  task automatic wb_transfer(input logic we, input dp_regs_pkg::wb_adr_t adr,
                             input dp_regs_pkg::wb_dat_t dat,
                             output dp_regs_pkg::wb_dat_t rdata);
    int waited;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    waited   = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > ack_wait_max) begin
        stop_on_error($sformatf("The DUT gave no Wishbone ack at address %0d.", adr));
      end
    end while (!wb_ack);
    rdata  = wb_dat_r;   // Stable through the ack cycle.
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
    idle_gap();
  endtask

  task automatic wb_write(input dp_regs_pkg::wb_adr_t adr, input dp_regs_pkg::wb_dat_t dat);
    dp_regs_pkg::wb_dat_t unused;
    wb_transfer(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input dp_regs_pkg::wb_adr_t adr, output dp_regs_pkg::wb_dat_t data);
    wb_transfer(1'b0, adr, '0, data);
  endtask

  //////////////////////////////
  // Case file
  //////////////////////////////

  // Next hex value with comment lines skipped.
  task automatic next_hex(output int value, output bit got);
    int r;
    int c;
    value = 0;
    r = $fscanf(fd, "%h", value);
    while (r == 0) begin
      c = $fgetc(fd);
      while (c != 10 && c != -1) begin
        c = $fgetc(fd);
      end
      r = $fscanf(fd, "%h", value);
    end
    got = (r == 1);
  endtask

  task automatic read_cases();
    int value;
    bit got;
    fd = $fopen("verif/dot_cases.txt", "r");
    if (fd == 0) begin
      stop_on_error("The case file verif/dot_cases.txt could not be opened.");
    end
    num_cases = 0;
    next_hex(value, got);
    while (got) begin
      if (num_cases == max_cases) begin
        stop_on_error("The case file holds more cases than the testbench can store.");
      end
      for (int j = 0; j < writes_per_case + 1; j++) begin
        if (j > 0) begin
          next_hex(value, got);
        end
        if (!got) begin
          stop_on_error("The case file ends in the middle of a case.");
        end
        if (j < dp_cfg_pkg::vec_len) begin
          case_a[num_cases][j] = dp_cfg_pkg::elem_t'(value[dp_cfg_pkg::data_width-1:0]);
        end else if (j < writes_per_case) begin
          case_b[num_cases][j-dp_cfg_pkg::vec_len] =
            dp_cfg_pkg::elem_t'(value[dp_cfg_pkg::data_width-1:0]);
        end else begin
          case_sum[num_cases] = dp_cfg_pkg::acc_t'(value[dp_cfg_pkg::acc_width-1:0]);
        end
      end
      num_cases++;
      next_hex(value, got);
    end
    $fclose(fd);
    if (num_cases == 0) begin
      stop_on_error("The case file holds no cases.");
    end
  endtask

  // Sum of signed products from the operands alone.
  function automatic dp_cfg_pkg::acc_t dot_ref(input int k);
    dp_cfg_pkg::acc_t s;
    s = '0;
    for (int i = 0; i < dp_cfg_pkg::vec_len; i++) begin
      s = s + dp_cfg_pkg::acc_t'(int'(case_a[k][i]) * int'(case_b[k][i]));
    end
    return s;
  endfunction

  //////////////////////////////
  // Run sequences
  //////////////////////////////

  task automatic run_start(input string name);
    dp_regs_pkg::wb_dat_t w;
    wb_write(dp_regs_pkg::reg_ctrl, 32'h1);
    wb_read(dp_regs_pkg::reg_status, w);
    check_status({name, " after start"}, 1'b1, 1'b0, w);   // Done cleared.
  endtask

  task automatic poll_done(input string name);
    dp_regs_pkg::wb_dat_t w;
    int polls;
    polls = 0;
    do begin
      wb_read(dp_regs_pkg::reg_status, w);
      polls++;
      if (!w[dp_regs_pkg::status_busy_bit] && !w[dp_regs_pkg::status_done_bit]) begin
        stop_on_error($sformatf("%s: status showed neither busy nor done.", name));
      end
    end while (!w[dp_regs_pkg::status_done_bit] && polls < poll_max);
    if (!w[dp_regs_pkg::status_done_bit]) begin
      stop_on_error($sformatf("%s: done was not set after %0d status polls.", name, polls));
    end
    check_status({name, " at done"}, 1'b0, 1'b1, w);
  endtask

  task automatic check_readback(input string name, input dp_cfg_pkg::acc_t exp);
    dp_regs_pkg::wb_dat_t w;
    wb_read(dp_regs_pkg::reg_result, w);
    check_result(name, exp, dp_cfg_pkg::acc_t'(w));
    check_word({name, " sign extension"}, dp_regs_pkg::wb_dat_t'(exp), w);
    wb_read(dp_regs_pkg::reg_runs, w);
    check_runs(name, runs_exp, dp_regs_pkg::runs_t'(w));
  endtask

  task automatic run_case(input int k);
    string name;
    name = $sformatf("case_%0d", k);
    check_result({name, " file"}, dot_ref(k), case_sum[k]);   // File cross-check.
    for (int i = 0; i < dp_cfg_pkg::vec_len; i++) begin
      wb_write(dp_regs_pkg::base_a + dp_regs_pkg::wb_adr_t'(i),
               dp_regs_pkg::wb_dat_t'(case_a[k][i]));
    end
    for (int i = 0; i < dp_cfg_pkg::vec_len; i++) begin
      wb_write(dp_regs_pkg::base_b + dp_regs_pkg::wb_adr_t'(i),
               dp_regs_pkg::wb_dat_t'(case_b[k][i]));
    end
    run_start(name);
    poll_done(name);
    runs_exp++;
    check_readback(name, case_sum[k]);
  endtask

  initial begin
    dp_regs_pkg::wb_dat_t w;
    int last;
    clk         = 1'b0;
    rst_n       = 1'b0;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    lfsr        = 32'hff9c7692;
    cycles      = 0;
    runs_exp    = '0;
    read_cases();
    cycle_limit = num_cases * (writes_per_case * 6 + poll_max * 4) + 200;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    // Reset state and unmapped reads.
    wb_read(dp_regs_pkg::reg_status, w);
    check_status("reset", 1'b0, 1'b0, w);
    check_word("reset status word", '0, w);
    wb_read(dp_regs_pkg::reg_result, w);
    check_result("reset", '0, dp_cfg_pkg::acc_t'(w));
    check_word("reset result word", '0, w);
    wb_read(dp_regs_pkg::reg_runs, w);
    check_runs("reset", '0, dp_regs_pkg::runs_t'(w));
    wb_read(6'd5, w);
    check_word("unmapped_5", '0, w);
    wb_read(6'd48, w);
    check_word("unmapped_48", '0, w);

    for (int k = 0; k < num_cases; k++) begin
      run_case(k);
    end

    // Operand and start writes while busy are dropped.
    last = num_cases - 1;
    run_start("busy_writes");
    wb_write(dp_regs_pkg::base_a, dp_regs_pkg::wb_dat_t'(~case_a[last][0]));
    wb_write(dp_regs_pkg::reg_ctrl, 32'h1);
    poll_done("busy_writes");
    runs_exp++;
    check_readback("busy_writes", case_sum[last]);

    // Unchanged operands give the same answer.
    run_start("repeat_start");
    poll_done("repeat_start");
    runs_exp++;
    check_readback("repeat_start", case_sum[last]);

    $display("Regression passed");
    $finish;
  end

endmodule

/* rtl/dot_top.sv */
`timescale 1ns/100ps

module dot_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  dp_regs_pkg::wb_adr_t wb_adr,
  input  dp_regs_pkg::wb_dat_t wb_dat_w,
  output dp_regs_pkg::wb_dat_t wb_dat_r,
  output logic                 wb_ack
);

  // Host write side.
  logic               wr_en_a, wr_en_b;
  dp_cfg_pkg::addr_t  wr_addr;
  dp_cfg_pkg::elem_t  wr_data;
  logic               start;

  // Loader side.
  logic               rd_en_a, rd_en_b;
  dp_cfg_pkg::addr_t  rd_addr_a, rd_addr_b;
  dp_cfg_pkg::elem_t  rd_data_a, rd_data_b;
  logic               a_loaded, b_loaded;
  dp_cfg_pkg::elem_t  vec_a [0:dp_cfg_pkg::vec_len-1];
  dp_cfg_pkg::elem_t  vec_b [0:dp_cfg_pkg::vec_len-1];

  // Compute and status.
  logic               exec_done;
  dp_cfg_pkg::acc_t   sum;
  logic               busy, done;
  dp_cfg_pkg::acc_t   result;
  dp_regs_pkg::runs_t runs;

  //////////////////////////////
  // Operand storage, loading
  //////////////////////////////

  operand_bram u_bram_a (
    .clk(clk), .wr_en(wr_en_a), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en_a), .rd_addr(rd_addr_a), .rd_data(rd_data_a)
  );

  operand_bram u_bram_b (
    .clk(clk), .wr_en(wr_en_b), .wr_addr(wr_addr), .wr_data(wr_data),
    .rd_en(rd_en_b), .rd_addr(rd_addr_b), .rd_data(rd_data_b)
  );

  vector_loader u_load_a (
    .clk(clk), .rst_n(rst_n), .start(start), .rd_en(rd_en_a), .rd_addr(rd_addr_a),
    .rd_data(rd_data_a), .loaded(a_loaded), .vec(vec_a)
  );

  vector_loader u_load_b (
    .clk(clk), .rst_n(rst_n), .start(start), .rd_en(rd_en_b), .rd_addr(rd_addr_b),
    .rd_data(rd_data_b), .loaded(b_loaded), .vec(vec_b)
  );

  //////////////////////////////
  // Bus, compute, status
  //////////////////////////////

  wb_decode u_decode (
    .clk(clk), .rst_n(rst_n), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
    .wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
    .busy(busy), .done(done), .result(result), .runs(runs),
    .wr_en_a(wr_en_a), .wr_en_b(wr_en_b), .wr_addr(wr_addr), .wr_data(wr_data),
    .start(start)
  );

  dot_execute u_execute (
    .clk(clk), .rst_n(rst_n), .a_loaded(a_loaded), .b_loaded(b_loaded),
    .vec_a(vec_a), .vec_b(vec_b), .exec_done(exec_done), .sum(sum)
  );

  result_status u_result (
    .clk(clk), .rst_n(rst_n), .start(start), .exec_done(exec_done), .sum(sum),
    .busy(busy), .done(done), .result(result), .runs(runs)
  );

endmodule

/* rtl/result_status.sv */
`timescale 1ns/100ps

module result_status (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               exec_done,
  input  dp_cfg_pkg::acc_t   sum,
  output logic               busy,
  output logic               done,
  output dp_cfg_pkg::acc_t   result,
  output dp_regs_pkg::runs_t runs
);

  //////////////////////////////
  // Status flags
  //////////////////////////////

  // Busy spans start to exec_done; done is sticky until the next start.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else if (start) begin
      busy <= 1'b1;
      done <= 1'b0;
    end else if (exec_done) begin
      busy <= 1'b0;
      done <= 1'b1;
    end
  end

  // Result and run count, both updated at completion.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result <= '0;
      runs   <= '0;
    end else if (exec_done) begin
      result <= sum;
      runs   <= runs + 1'b1;   // Wraps at 255.
    end
  end

endmodule

/* rtl/dot_execute.sv */
`timescale 1ns/100ps

module dot_execute (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              a_loaded,
  input  logic              b_loaded,
  input  dp_cfg_pkg::elem_t vec_a [0:dp_cfg_pkg::vec_len-1],
  input  dp_cfg_pkg::elem_t vec_b [0:dp_cfg_pkg::vec_len-1],
  output logic              exec_done,
  output dp_cfg_pkg::acc_t  sum
);

  logic                                       active;
  dp_cfg_pkg::idx_t                           idx;
  dp_cfg_pkg::addr_t                          sel;
  logic signed [2*dp_cfg_pkg::data_width-1:0] prod;
  dp_cfg_pkg::acc_t                           acc;

  //////////////////////////////
  // Element select, product
  //////////////////////////////

  assign sel  = idx[dp_cfg_pkg::addr_width-1:0];
  assign prod = vec_a[sel] * vec_b[sel];   // Signed 8 x 8.

  //////////////////////////////
  // Sequencer
  //////////////////////////////

  // Launch only when both arrays land together.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      active    <= 1'b0;
      idx       <= '0;
      exec_done <= 1'b0;
    end else begin
      exec_done <= 1'b0;
      if (a_loaded && b_loaded) begin
        active <= 1'b1;
        idx    <= '0;
      end else if (active) begin
        idx <= idx + 1'b1;
        if (idx == dp_cfg_pkg::idx_t'(dp_cfg_pkg::vec_len - 1)) begin
          active    <= 1'b0;
          exec_done <= 1'b1;   // Last term added.
        end
      end
    end
  end

  // Accumulator, one term per active cycle.
  always_ff @(posedge clk) begin
    if (a_loaded && b_loaded) begin
      acc <= '0;
    end else if (active) begin
      acc <= acc + dp_cfg_pkg::acc_t'(prod);
    end
  end

  assign sum = acc;

endmodule

/* rtl/wb_decode.sv */
`timescale 1ns/100ps

module wb_decode (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 wb_cyc,
  input  logic                 wb_stb,
  input  logic                 wb_we,
  input  dp_regs_pkg::wb_adr_t wb_adr,
  input  dp_regs_pkg::wb_dat_t wb_dat_w,
  output dp_regs_pkg::wb_dat_t wb_dat_r,
  output logic                 wb_ack,
  input  logic                 busy,
  input  logic                 done,
  input  dp_cfg_pkg::acc_t     result,
  input  dp_regs_pkg::runs_t   runs,
  output logic                 wr_en_a,
  output logic                 wr_en_b,
  output dp_cfg_pkg::addr_t    wr_addr,
  output dp_cfg_pkg::elem_t    wr_data,
  output logic                 start
);

  localparam int sign_bits = dp_regs_pkg::wb_dat_width - dp_cfg_pkg::acc_width;

  logic                 req;
  logic                 wr_ok;     // Write request the core may take.
  logic                 in_a;
  logic                 in_b;
  dp_regs_pkg::wb_dat_t rd_mux;

  // New request, not the cycle already being acknowledged.
  assign req   = wb_cyc && wb_stb && !wb_ack;
  assign wr_ok = req && wb_we && !busy;

  // Region select from the upper address bits.
  assign in_a = wb_adr[dp_regs_pkg::wb_adr_width-1:dp_cfg_pkg::addr_width] ==
                (dp_regs_pkg::base_a >> dp_cfg_pkg::addr_width);
  assign in_b = wb_adr[dp_regs_pkg::wb_adr_width-1:dp_cfg_pkg::addr_width] ==
                (dp_regs_pkg::base_b >> dp_cfg_pkg::addr_width);

  //////////////////////////////
  // Handshake and control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_ack  <= 1'b0;
      wr_en_a <= 1'b0;
      wr_en_b <= 1'b0;
      start   <= 1'b0;
    end else begin
      wb_ack  <= req;                          // One cycle, one cycle late.
      wr_en_a <= wr_ok && in_a;
      wr_en_b <= wr_ok && in_b;
      start   <= wr_ok && (wb_adr == dp_regs_pkg::reg_ctrl) && wb_dat_w[0];
    end
  end

  // Operand payload, used with the enables above.
  always_ff @(posedge clk) begin
    wr_addr <= wb_adr[dp_cfg_pkg::addr_width-1:0];
    wr_data <= dp_cfg_pkg::elem_t'(wb_dat_w[dp_cfg_pkg::data_width-1:0]);
  end

  //////////////////////////////
  // Read data
  //////////////////////////////

  always_comb begin
    rd_mux = '0;  // Unmapped reads return zero.
    case (wb_adr)
      dp_regs_pkg::reg_status: begin
        rd_mux[dp_regs_pkg::status_busy_bit] = busy;
        rd_mux[dp_regs_pkg::status_done_bit] = done;
      end
      dp_regs_pkg::reg_result: rd_mux = {{sign_bits{result[dp_cfg_pkg::acc_width-1]}}, result};
      dp_regs_pkg::reg_runs:   rd_mux = dp_regs_pkg::wb_dat_t'(runs);
      default:                 rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_mux;   // Valid in the ack cycle.
    end
  end

endmodule

/* rtl/vector_loader.sv */
`timescale 1ns/100ps

module vector_loader (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  output logic              rd_en,
  output dp_cfg_pkg::addr_t rd_addr,
  input  dp_cfg_pkg::elem_t rd_data,
  output logic              loaded,
  output dp_cfg_pkg::elem_t vec [0:dp_cfg_pkg::vec_len-1]
);

  logic              running;
  dp_cfg_pkg::addr_t addr_cnt;
  logic              valid_q1;
  logic              valid_q2;
  dp_cfg_pkg::addr_t idx_q1;
  dp_cfg_pkg::addr_t idx_q2;

  //////////////////////////////
  // Address issue
  //////////////////////////////

  // One address per cycle for vec_len cycles after start.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      running  <= 1'b0;
      addr_cnt <= '0;
    end else if (start) begin
      running  <= 1'b1;
      addr_cnt <= '0;
    end else if (running) begin
      addr_cnt <= addr_cnt + 1'b1;
      if (addr_cnt == dp_cfg_pkg::addr_t'(dp_cfg_pkg::vec_len - 1)) begin
        running <= 1'b0;  // Last address issued.
      end
    end
  end

  assign rd_en   = running;
  assign rd_addr = addr_cnt;

  //////////////////////////////
  // Latency alignment
  //////////////////////////////

  // Valid and index follow the RAM's two read stages.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q1 <= 1'b0;
      valid_q2 <= 1'b0;
    end else begin
      valid_q1 <= rd_en;
      valid_q2 <= valid_q1;
    end
  end

  always_ff @(posedge clk) begin
    idx_q1 <= rd_addr;
    idx_q2 <= idx_q1;
  end

  // Each slot takes the returning word only when its index comes back.
  for (genvar i = 0; i < dp_cfg_pkg::vec_len; i++) begin : g_slot
    always_ff @(posedge clk) begin
      if (!rst_n) begin
        vec[i] <= '0;
      end else if (valid_q2 && (idx_q2 == dp_cfg_pkg::addr_t'(i))) begin
        vec[i] <= rd_data;
      end
    end
  end

  // Pulse once the last element is in.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      loaded <= 1'b0;
    end else begin
      loaded <= valid_q2 &&
                (idx_q2 == dp_cfg_pkg::addr_t'(dp_cfg_pkg::vec_len - 1));
    end
  end

endmodule

/* rtl/operand_bram.sv */
`timescale 1ns/100ps

module operand_bram (
  input  logic              clk,
  input  logic              wr_en,
  input  dp_cfg_pkg::addr_t wr_addr,
  input  dp_cfg_pkg::elem_t wr_data,
  input  logic              rd_en,
  input  dp_cfg_pkg::addr_t rd_addr,
  output dp_cfg_pkg::elem_t rd_data
);

  dp_cfg_pkg::elem_t mem [0:dp_cfg_pkg::vec_len-1];
  dp_cfg_pkg::elem_t rd_q;      // Registered array read.
  logic              rd_en_q;

  // Write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  //////////////////////////////
  // Read path, two cycles
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_q <= mem[rd_addr];   // First stage.
    end
    rd_en_q <= rd_en;
  end

  // Output register follows the first stage one cycle later.
  always_ff @(posedge clk) begin
    if (rd_en_q) begin
      rd_data <= rd_q;
    end
  end

endmodule

/* rtl/dp_regs_pkg.sv */
package dp_regs_pkg;

  //////////////////////////////
  // Wishbone widths
  //////////////////////////////

  localparam int wb_adr_width = 6;   // Word address.
  localparam int wb_dat_width = 32;

  typedef logic [wb_adr_width-1:0] wb_adr_t;
  typedef logic [wb_dat_width-1:0] wb_dat_t;

  //////////////////////////////
  // Register map
  //////////////////////////////

  localparam wb_adr_t reg_ctrl   = 6'd0;   // Bit 0 starts a run.
  localparam wb_adr_t reg_status = 6'd1;   // Read only.
  localparam wb_adr_t reg_result = 6'd2;   // Sign-extended sum.
  localparam wb_adr_t reg_runs   = 6'd3;   // Zero-extended run count.

  // Operand regions, 16 words each.
  localparam wb_adr_t base_a = 6'd16;
  localparam wb_adr_t base_b = 6'd32;

  // Status bits.
  localparam int status_busy_bit = 0;
  localparam int status_done_bit = 1;

  typedef logic [7:0] runs_t;

endpackage

/* rtl/dp_cfg_pkg.sv */
package dp_cfg_pkg;

  //////////////////////////////
  // Sizes
  //////////////////////////////

  localparam int data_width = 8;   // Element width.
  localparam int vec_len    = 16;  // Elements per vector.
  localparam int addr_width = 4;   // Operand RAM address width.
  localparam int acc_width  = 24;  // Wide enough for 16 full-scale products.

  //////////////////////////////
  // Arithmetic types
  //////////////////////////////

  // One operand element.
  typedef logic signed [data_width-1:0] elem_t;

  // Running and final sum.
  typedef logic signed [acc_width-1:0] acc_t;

  // Operand RAM address.
  typedef logic [addr_width-1:0] addr_t;

  // One extra bit so a counter can reach vec_len.
  typedef logic [addr_width:0] idx_t;

endpackage
